// ==== files.f ====
source/icache_pkg.sv
source/icache_ctrl.sv
source/icache_tag_store.sv
source/icache_data_store.sv
source/icache_top.sv
dv/icache_props.sv
dv/icache_tb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the icache testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --assert --top-module icache_tb -f files.f \
    --Mdir obj_dir -o icache_sim

./obj_dir/icache_sim | tee sim.log

if grep -qx '>>> PASS' sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi

// ==== dv/icache_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module icache_tb;

    localparam int num_entries = 13;
    localparam int num_lines   = 4;
    localparam int stream_len  = 12;
    localparam int timeout_cycles = (num_entries + num_lines + stream_len) * 8 + 64;

    // memory contents rule, one key per word of a line
    localparam logic [31:0] low_key  = 32'h5a5a_0f0f;
    localparam logic [31:0] high_key = 32'hc3c3_9696;

    logic clk = 1'b0;
    logic rst;
    logic valid;
    icache_pkg::fetch_req_t req;
    logic        addr_ok;
    logic        data_ok;
    logic [31:0] rdata;
    logic        rd_req;
    logic [31:0] rd_addr;
    logic [63:0] ret_data;

    int          rd_count;
    logic [31:0] last_rd_addr;
    int          errors = 0;
    int          checks = 0;
    int          cycle_count = 0;
    logic [31:0] lfsr_state = 32'h76ef3c25;

    // stimulus table
    icache_pkg::fetch_req_t tbl_req  [num_entries];
    logic                   tbl_miss [num_entries];
    string                  tbl_name [num_entries];
    int                     tbl_fill = 0;

    icache_pkg::fetch_req_t rand_line  [num_lines];
    icache_pkg::fetch_req_t stream_req [stream_len];

    icache_top u_dut (
        .clk      (clk),
        .rst      (rst),
        .valid    (valid),
        .req      (req),
        .addr_ok  (addr_ok),
        .data_ok  (data_ok),
        .rdata    (rdata),
        .rd_req   (rd_req),
        .rd_addr  (rd_addr),
        .ret_data (ret_data)
    );

    always #50 clk = ~clk;

    function automatic logic [63:0] line_for(input logic [31:0] line_addr);
        return {line_addr ^ high_key, line_addr ^ low_key};
    endfunction

    function automatic logic [31:0] expected_word(input logic [31:0] addr);
        logic [31:0] line_addr;
        line_addr = {addr[31:3], 3'b000};
        if (addr[2]) begin
            return line_addr ^ high_key;
        end
        return line_addr ^ low_key;
    endfunction

    // memory answers in the same cycle
    always_comb begin
        ret_data = rd_req ? line_for(rd_addr) : 64'h0;
    end

    always @(posedge clk) begin
        if (rst) begin
            rd_count <= 0;
        end else if (rd_req) begin
            rd_count     <= rd_count + 1;
            last_rd_addr <= rd_addr;
        end
    end

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic take_bits(input int n, output logic [31:0] value);
        int k;
        value = '0;
        for (k = 0; k < n; k++) begin
            lfsr_state = lfsr_next(lfsr_state);
            value = {value[30:0], lfsr_state[0]};
        end
    endtask

    function automatic icache_pkg::fetch_req_t make_req(
        input logic [icache_pkg::tag_w-1:0]    tag,
        input logic [icache_pkg::index_w-1:0]  index,
        input logic [icache_pkg::offset_w-1:0] offset
    );
        icache_pkg::fetch_req_t r;
        r.tag    = tag;
        r.index  = index;
        r.offset = offset;
        return r;
    endfunction

    task automatic add_entry(input icache_pkg::fetch_req_t r, input logic miss,
                             input string name);
        tbl_req[tbl_fill]  = r;
        tbl_miss[tbl_fill] = miss;
        tbl_name[tbl_fill] = name;
        tbl_fill++;
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        checks++;
        if (expected !== actual) begin
            errors++;
            $display("FAIL %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    // one request, valid dropped once it is taken
    task automatic run_request(input icache_pkg::fetch_req_t r, input logic miss,
                               input string name);
        int   start_count;
        int   latency;
        logic took;
        start_count = rd_count;
        took = 1'b0;
        @(posedge clk);
        valid <= 1'b1;
        req   <= r;
        while (!took) begin
            @(negedge clk);
            took = addr_ok;
            @(posedge clk);
        end
        valid <= 1'b0;
        latency = 0;
        do begin
            @(negedge clk);
            latency++;
        end while (!data_ok);
        check_value({name, " data"}, expected_word(r), rdata);
        check_value({name, " latency"}, miss ? 32'd4 : 32'd1, latency);
        check_value({name, " reads"}, miss ? 32'd1 : 32'd0, rd_count - start_count);
        if (miss) begin
            check_value({name, " rd_addr"}, {r[31:3], 3'b000}, last_rd_addr);
        end
    endtask

    // valid held high, next address given on every acceptance
    task automatic run_stream(input string name);
        logic [31:0] exp_q [$];
        logic [31:0] exp;
        logic        take;
        int          sent;
        int          got;
        int          gaps;
        int          start_count;
        sent = 0;
        got  = 0;
        gaps = 0;
        start_count = rd_count;
        @(posedge clk);
        valid <= 1'b1;
        req   <= stream_req[0];
        while (got < stream_len) begin
            @(negedge clk);
            if (data_ok) begin
                if (exp_q.size() == 0) begin
                    errors++;
                    $display("%s: data_ok came with no request outstanding", name);
                end else begin
                    exp = exp_q.pop_front();
                    check_value($sformatf("%s word %0d", name, got), exp, rdata);
                end
                got++;
            end else if (sent > 0) begin
                gaps++;
            end
            take = valid && addr_ok;
            @(posedge clk);
            if (take) begin
                exp_q.push_back(expected_word(stream_req[sent]));
                sent++;
                if (sent < stream_len) begin
                    req <= stream_req[sent];
                end else begin
                    valid <= 1'b0;
                end
            end
        end
        check_value({name, " stall cycles"}, 32'd0, gaps);
        check_value({name, " reads"}, 32'd0, rd_count - start_count);
    endtask

    initial begin : watchdog
        while (cycle_count < timeout_cycles) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("timeout: run did not finish within %0d cycles", timeout_cycles);
        $display(">>> FAIL");
        $finish;
    end

    initial begin : stimulus
        int          i;
        logic [31:0] bits;
        logic [31:0] obit;
        rst   <= 1'b1;
        valid <= 1'b0;
        req   <= '0;

        add_entry(make_req(23'h000012, 6'd5, 3'd0), 1'b1, "cold_miss");
        add_entry(make_req(23'h000012, 6'd5, 3'd0), 1'b0, "repeat_hit");
        add_entry(make_req(23'h000034, 6'd6, 3'd4), 1'b1, "word_high_miss");
        add_entry(make_req(23'h000034, 6'd6, 3'd0), 1'b0, "word_low_hit");
        // set 9 holds tags 0x100 and 0x200, then 0x300 pushes out the oldest
        add_entry(make_req(23'h000100, 6'd9, 3'd0), 1'b1, "way_a_fill");
        add_entry(make_req(23'h000200, 6'd9, 3'd4), 1'b1, "way_b_fill");
        add_entry(make_req(23'h000100, 6'd9, 3'd4), 1'b0, "way_a_hit");
        add_entry(make_req(23'h000200, 6'd9, 3'd0), 1'b0, "way_b_hit");
        add_entry(make_req(23'h000300, 6'd9, 3'd0), 1'b1, "evict_fill");
        add_entry(make_req(23'h000200, 6'd9, 3'd4), 1'b0, "way_b_kept");
        add_entry(make_req(23'h000100, 6'd9, 3'd0), 1'b1, "way_a_evicted");
        add_entry(make_req(23'h000300, 6'd9, 3'd4), 1'b0, "way_c_hit");
        add_entry(make_req(23'h000100, 6'd9, 3'd4), 1'b0, "way_a_refilled");

        repeat (5) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        check_value("reset addr_ok", 32'd1, 32'(addr_ok));
        check_value("reset data_ok", 32'd0, 32'(data_ok));
        check_value("reset rd_req", 32'd0, 32'(rd_req));

        for (i = 0; i < num_entries; i++) begin
            run_request(tbl_req[i], tbl_miss[i], tbl_name[i]);
        end

        // random tags on sets 40 and up, away from the fixed entries
        for (i = 0; i < num_lines; i++) begin
            take_bits(icache_pkg::tag_w, bits);
            rand_line[i] = make_req(bits[22:0], 6'd40 + 6'(i), 3'd0);
            run_request(rand_line[i], 1'b1, $sformatf("rand_fill_%0d", i));
        end
        for (i = 0; i < stream_len; i++) begin
            take_bits(2, bits);
            take_bits(1, obit);
            stream_req[i] = rand_line[bits[1:0]];
            stream_req[i].offset = {obit[0], 2'b00};
        end
        run_stream("back_to_back");

        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== dv/icache_props.sv ====
`timescale 1ns/1ps
`default_nettype none

module icache_props (
    input  wire                       clk,
    input  wire                       rst,
    input  icache_pkg::cache_state_t  state,
    input  wire                       valid,
    input  wire                       addr_ok,
    input  wire                       data_ok,
    input  wire                       rd_req
);

    // memory strobe is a single pulse per refill
    rd_req_one_cycle: assert property (
        @(posedge clk) disable iff (rst) rd_req |=> !rd_req
    ) else $error("rd_req stayed high for more than one cycle");

    // no new request is taken while a refill is in progress
    no_accept_during_read: assert property (
        @(posedge clk) disable iff (rst) rd_req |-> !addr_ok ##1 !addr_ok
    ) else $error("addr_ok was high while a refill was in progress");

    // each word answers a request taken the cycle before or a replay
    data_only_in_lookup: assert property (
        @(posedge clk) disable iff (rst)
        data_ok |-> (state == icache_pkg::lookup)
                    && ($past(valid && addr_ok) || $past(state == icache_pkg::replace))
    ) else $error("data_ok came without an accepted or replayed request in lookup");

    // miss, replace, then the replayed lookup returns the word
    refill_returns_word: assert property (
        @(posedge clk) disable iff (rst) $past(rd_req, 2) |-> data_ok
    ) else $error("data_ok did not follow rd_req two cycles later");

endmodule

bind icache_ctrl icache_props u_props (
    .clk     (clk),
    .rst     (rst),
    .state   (state),
    .valid   (valid),
    .addr_ok (addr_ok),
    .data_ok (data_ok),
    .rd_req  (rd_req)
);

`default_nettype wire

// ==== source/icache_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module icache_top (
    input  wire                             clk,
    input  wire                             rst,
    // fetch side
    input  wire                             valid,
    input  icache_pkg::fetch_req_t          req,
    output logic                            addr_ok,
    output logic                            data_ok,
    output logic [icache_pkg::word_w-1:0]   rdata,
    // memory side
    output logic                            rd_req,
    output logic [31:0]                     rd_addr,
    input  wire [icache_pkg::line_w-1:0]    ret_data
);

    logic [icache_pkg::index_w-1:0] lookup_index;
    icache_pkg::fetch_req_t         held_req;
    icache_pkg::tag_write_t         tag_wr;
    icache_pkg::line_write_t        line_wr;
    logic                           hit_way0;
    logic                           hit_way1;
    logic                           victim_way;

    icache_ctrl u_ctrl (
        .clk          (clk),
        .rst          (rst),
        .valid        (valid),
        .req          (req),
        .hit_way0     (hit_way0),
        .hit_way1     (hit_way1),
        .victim_way   (victim_way),
        .ret_data     (ret_data),
        .lookup_index (lookup_index),
        .held_req     (held_req),
        .tag_wr       (tag_wr),
        .line_wr      (line_wr),
        .addr_ok      (addr_ok),
        .data_ok      (data_ok),
        .rd_req       (rd_req),
        .rd_addr      (rd_addr)
    );

    icache_tag_store u_tag_store (
        .clk          (clk),
        .rst          (rst),
        .lookup_index (lookup_index),
        .held_req     (held_req),
        .tag_wr       (tag_wr),
        .hit_way0     (hit_way0),
        .hit_way1     (hit_way1),
        .victim_way   (victim_way)
    );

    // word select uses the offset of the buffered request
    icache_data_store u_data_store (
        .clk          (clk),
        .lookup_index (lookup_index),
        .offset       (held_req.offset),
        .hit_way0     (hit_way0),
        .hit_way1     (hit_way1),
        .line_wr      (line_wr),
        .rdata        (rdata)
    );

endmodule

`default_nettype wire

// ==== source/icache_data_store.sv ====
`timescale 1ns/1ps
`default_nettype none

module icache_data_store (
    input  wire                             clk,
    input  wire [icache_pkg::index_w-1:0]   lookup_index,
    input  wire [icache_pkg::offset_w-1:0]  offset,
    input  wire                             hit_way0,
    input  wire                             hit_way1,
    input  icache_pkg::line_write_t         line_wr,
    output logic [icache_pkg::word_w-1:0]   rdata
);

    logic [icache_pkg::line_w-1:0] lines0 [icache_pkg::num_sets];
    logic [icache_pkg::line_w-1:0] lines1 [icache_pkg::num_sets];

    logic [icache_pkg::line_w-1:0] line0_q;
    logic [icache_pkg::line_w-1:0] line1_q;

    logic wr0;
    logic wr1;
    logic fwd;
    logic word_sel;

    logic [icache_pkg::word_w-1:0] word0;
    logic [icache_pkg::word_w-1:0] word1;

    // one way written per refill
    assign wr0 = line_wr.we && !line_wr.way;
    assign wr1 = line_wr.we && line_wr.way;
    assign fwd = (line_wr.index == lookup_index);

    always_ff @(posedge clk) begin
        if (wr0) begin
            lines0[line_wr.index] <= line_wr.data;
        end
        if (wr1) begin
            lines1[line_wr.index] <= line_wr.data;
        end
        // write-first on a same-set read, like the tag store
        line0_q <= (wr0 && fwd) ? line_wr.data : lines0[lookup_index];
        line1_q <= (wr1 && fwd) ? line_wr.data : lines1[lookup_index];
    end

    // byte offset bit 2 picks the upper word
    assign word_sel = offset[icache_pkg::offset_w-1];

    always_comb begin
        if (word_sel) begin
            word0 = line0_q[icache_pkg::word_w +: icache_pkg::word_w];
            word1 = line1_q[icache_pkg::word_w +: icache_pkg::word_w];
        end else begin
            word0 = line0_q[0 +: icache_pkg::word_w];
            word1 = line1_q[0 +: icache_pkg::word_w];
        end
    end

    // at most one way hits, so an and-or mux is enough
    assign rdata = ({icache_pkg::word_w{hit_way0}} & word0)
                 | ({icache_pkg::word_w{hit_way1}} & word1);

endmodule

`default_nettype wire

// ==== source/icache_tag_store.sv ====
`timescale 1ns/1ps
`default_nettype none

module icache_tag_store (
    input  wire                             clk,
    input  wire                             rst,
    input  wire [icache_pkg::index_w-1:0]   lookup_index,
    input  icache_pkg::fetch_req_t          held_req,
    input  icache_pkg::tag_write_t          tag_wr,
    output logic                            hit_way0,
    output logic                            hit_way1,
    output logic                            victim_way
);

    logic [icache_pkg::num_sets-1:0] valid0;
    logic [icache_pkg::num_sets-1:0] valid1;
    // round-robin bit per set, names the way to fill next
    logic [icache_pkg::num_sets-1:0] victim;

    logic [icache_pkg::tag_w-1:0] tags0 [icache_pkg::num_sets];
    logic [icache_pkg::tag_w-1:0] tags1 [icache_pkg::num_sets];

    logic                         v0_q;
    logic                         v1_q;
    logic [icache_pkg::tag_w-1:0] tag0_q;
    logic [icache_pkg::tag_w-1:0] tag1_q;

    logic wr_way;
    logic wr0;
    logic wr1;
    logic fwd;

    assign wr_way = victim[tag_wr.index];
    assign wr0    = tag_wr.we && !wr_way;
    assign wr1    = tag_wr.we && wr_way;
    // write and read of the same set in one cycle return the new entry
    assign fwd    = (tag_wr.index == lookup_index);

    always_ff @(posedge clk) begin
        if (rst) begin
            valid0 <= '0;
            valid1 <= '0;
            victim <= '0;
            v0_q   <= 1'b0;
            v1_q   <= 1'b0;
        end else begin
            if (wr0) begin
                valid0[tag_wr.index] <= 1'b1;
            end
            if (wr1) begin
                valid1[tag_wr.index] <= 1'b1;
            end
            if (tag_wr.we) begin
                victim[tag_wr.index] <= ~victim[tag_wr.index];
            end
            v0_q <= (wr0 && fwd) || valid0[lookup_index];
            v1_q <= (wr1 && fwd) || valid1[lookup_index];
        end
    end

    always_ff @(posedge clk) begin
        if (wr0) begin
            tags0[tag_wr.index] <= tag_wr.tag;
        end
        if (wr1) begin
            tags1[tag_wr.index] <= tag_wr.tag;
        end
        tag0_q <= (wr0 && fwd) ? tag_wr.tag : tags0[lookup_index];
        tag1_q <= (wr1 && fwd) ? tag_wr.tag : tags1[lookup_index];
    end

    // compare against the buffered request
    assign hit_way0 = v0_q && (tag0_q == held_req.tag);
    assign hit_way1 = v1_q && (tag1_q == held_req.tag);

    assign victim_way = victim[held_req.index];

endmodule

`default_nettype wire

// ==== source/icache_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module icache_ctrl (
    input  wire                             clk,
    input  wire                             rst,
    // fetch side
    input  wire                             valid,
    input  icache_pkg::fetch_req_t          req,
    // results from the tag store
    input  wire                             hit_way0,
    input  wire                             hit_way1,
    input  wire                             victim_way,
    // memory side
    input  wire [icache_pkg::line_w-1:0]    ret_data,
    // towards both stores
    output logic [icache_pkg::index_w-1:0]  lookup_index,
    output icache_pkg::fetch_req_t          held_req,
    output icache_pkg::tag_write_t          tag_wr,
    output icache_pkg::line_write_t         line_wr,
    // handshake
    output logic                            addr_ok,
    output logic                            data_ok,
    output logic                            rd_req,
    output logic [31:0]                     rd_addr
);

    icache_pkg::cache_state_t state;
    icache_pkg::cache_state_t next_state;

    logic                          hit;
    logic                          accept;
    logic [icache_pkg::line_w-1:0] miss_line;

    assign hit = hit_way0 | hit_way1;

    // a hit in lookup frees the buffer for the next request
    assign addr_ok = (state == icache_pkg::idle) || (state == icache_pkg::lookup && hit);
    assign accept  = valid && addr_ok;
    assign data_ok = (state == icache_pkg::lookup) && hit;

    // single cycle strobe, memory answers in the same cycle
    assign rd_req  = (state == icache_pkg::miss);
    assign rd_addr = {held_req.tag, held_req.index, {icache_pkg::offset_w{1'b0}}};

    // replace re-reads the held set so the replayed lookup sees the new line
    assign lookup_index = (state == icache_pkg::replace) ? held_req.index : req.index;

    always_comb begin
        next_state = state;
        case (state)
            icache_pkg::idle: begin
                if (valid) begin
                    next_state = icache_pkg::lookup;
                end
            end
            icache_pkg::lookup: begin
                if (!hit) begin
                    next_state = icache_pkg::miss;
                end else if (!valid) begin
                    next_state = icache_pkg::idle;
                end
            end
            icache_pkg::miss: begin
                next_state = icache_pkg::replace;
            end
            icache_pkg::replace: begin
                // replay the held request
                next_state = icache_pkg::lookup;
            end
            default: begin
                next_state = icache_pkg::idle;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= icache_pkg::idle;
        end else begin
            state <= next_state;
        end
    end

    // request buffer
    always_ff @(posedge clk) begin
        if (accept) begin
            held_req <= req;
        end
    end

    // miss buffer, line captured while rd_req is high
    always_ff @(posedge clk) begin
        if (state == icache_pkg::miss) begin
            miss_line <= ret_data;
        end
    end

    // refill writes
    always_comb begin
        tag_wr.we    = (state == icache_pkg::replace);
        tag_wr.index = held_req.index;
        tag_wr.tag   = held_req.tag;
    end

    always_comb begin
        line_wr.we    = (state == icache_pkg::replace);
        line_wr.way   = victim_way;
        line_wr.index = held_req.index;
        line_wr.data  = miss_line;
    end

endmodule

`default_nettype wire

// ==== source/icache_pkg.sv ====
`default_nettype none

package icache_pkg;

    // address split and cache geometry
    localparam int tag_w    = 23;
    localparam int index_w  = 6;
    localparam int offset_w = 3;
    localparam int num_sets = 64;
    localparam int line_w   = 64;
    localparam int word_w   = 32;

    // fetch address as seen on the fetch port
    typedef struct packed {
        logic [tag_w-1:0]    tag;
        logic [index_w-1:0]  index;
        logic [offset_w-1:0] offset;
    } fetch_req_t;

    // refill of one tag entry, the way comes from the victim bit
    typedef struct packed {
        logic               we;
        logic [index_w-1:0] index;
        logic [tag_w-1:0]   tag;
    } tag_write_t;

    // refill of one line into one way
    typedef struct packed {
        logic               we;
        logic               way;
        logic [index_w-1:0] index;
        logic [line_w-1:0]  data;
    } line_write_t;

    typedef enum logic [1:0] {
        idle    = 2'd0,
        lookup  = 2'd1,
        miss    = 2'd2,
        replace = 2'd3
    } cache_state_t;

endpackage

`default_nettype wire
